// ==== logic/hub_consts.svh ====
`ifndef HUB_CONSTS_SVH
`define HUB_CONSTS_SVH

// Number of physical buses on the hub.
`define HUB_NUM_CHANNELS 32

// Recessive level of a CAN line.
`define HUB_IDLE_LEVEL 1'b1

// Register map.
`define HUB_ADDR_CTRL     8'h00
`define HUB_ADDR_ACTIVITY 8'h04
`define HUB_ADDR_LEVEL    8'h08

// Field positions in the control word.
`define HUB_CTRL_CHAN_MSB 4
`define HUB_CTRL_EN_BIT   8

`endif

// ==== logic/apb_pkg.sv ====
package apb_pkg;

  // Byte address of the register block.
  typedef logic [7:0] apb_addr_t;

  // Read and write data word.
  typedef logic [31:0] apb_data_t;

endpackage

// ==== logic/hub_pkg.sv ====
`include "hub_consts.svh"

package hub_pkg;

  // Index of one physical bus.
  typedef logic [$clog2(`HUB_NUM_CHANNELS)-1:0] channel_t;

  // One bit per bus, for line values, levels and activity flags.
  typedef logic [`HUB_NUM_CHANNELS-1:0] chan_vec_t;

  // Routing control as held in the register block.
  typedef struct packed {
    logic     enable;
    channel_t channel;
  } ctrl_reg_t;

endpackage

// ==== logic/route_if.sv ====
`timescale 1ns/1ps

interface route_if;

  hub_pkg::ctrl_reg_t ctrl;           // Selected bus and global enable.
  hub_pkg::chan_vec_t activity_clear; // Write-one-to-clear pulse, one cycle wide.
  hub_pkg::chan_vec_t activity;       // Sticky dominant-bit flags.
  hub_pkg::chan_vec_t level;          // Synchronized bus levels.

  modport regs (
    output ctrl,
    output activity_clear,
    input  activity,
    input  level
  );

  modport tx (
    input ctrl
  );

  modport rx (
    input  ctrl,
    output level
  );

  modport mon (
    input  level,
    input  activity_clear,
    output activity
  );

endinterface

// ==== logic/switch_regs.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module switch_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  apb_pkg::apb_addr_t paddr,
  input  apb_pkg::apb_data_t pwdata,
  output apb_pkg::apb_data_t prdata,
  route_if.regs              route
);

  logic               access;
  logic               wr_en;
  logic               rd_en;
  hub_pkg::ctrl_reg_t ctrl_q;
  apb_pkg::apb_data_t ctrl_word;
  apb_pkg::apb_data_t rd_word;

  assign access = psel && penable; // Every access completes in its access phase.
  assign wr_en  = access && pwrite;
  assign rd_en  = access && !pwrite;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (wr_en && (paddr == `HUB_ADDR_CTRL)) begin
      ctrl_q.channel <= pwdata[`HUB_CTRL_CHAN_MSB:0];
      ctrl_q.enable  <= pwdata[`HUB_CTRL_EN_BIT];
    end
  end

  assign route.ctrl = ctrl_q;

  // Control word as software sees it.
  always_comb begin
    ctrl_word                       = '0;
    ctrl_word[`HUB_CTRL_CHAN_MSB:0] = ctrl_q.channel;
    ctrl_word[`HUB_CTRL_EN_BIT]     = ctrl_q.enable;
  end

  // The clear pulse lasts only for the access phase, so the monitor acts on
  // the same edge that ends the write.
  always_comb begin
    route.activity_clear = '0;
    if (wr_en && (paddr == `HUB_ADDR_ACTIVITY)) begin
      route.activity_clear = pwdata[`HUB_NUM_CHANNELS-1:0];
    end
  end

  always_comb begin
    case (paddr)
      `HUB_ADDR_CTRL: begin
        rd_word = ctrl_word;
      end
      `HUB_ADDR_ACTIVITY: begin
        rd_word = route.activity;
      end
      `HUB_ADDR_LEVEL: begin
        rd_word = route.level;
      end
      default: begin
        rd_word = '0; // Unmapped addresses read as zero.
      end
    endcase
  end

  assign prdata = rd_en ? rd_word : '0;

  ctrl_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(route.ctrl)
  ) else $error("switch_regs: control register is unknown");

endmodule

// ==== logic/tx_demux.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module tx_demux #(
  parameter logic idle_value = `HUB_IDLE_LEVEL
) (
  input  logic               tx,
  output hub_pkg::chan_vec_t bus_tx,
  route_if.tx                route
);

  // Only the selected bus carries the controller's bit; all others stay recessive.
  always_comb begin
    bus_tx = {`HUB_NUM_CHANNELS{idle_value}};
    if (route.ctrl.enable) begin
      bus_tx[route.ctrl.channel] = tx;
    end
  end

endmodule

// ==== logic/rx_select.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module rx_select (
  input  logic               clk,
  input  logic               rst_n,
  input  hub_pkg::chan_vec_t bus_rx,
  output logic               rx,
  route_if.rx                route
);

  hub_pkg::chan_vec_t meta_q;
  hub_pkg::chan_vec_t sync_q;

  // Two-stage synchronizer on every receive line.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q <= {`HUB_NUM_CHANNELS{`HUB_IDLE_LEVEL}};
      sync_q <= {`HUB_NUM_CHANNELS{`HUB_IDLE_LEVEL}};
    end else begin
      meta_q <= bus_rx;
      sync_q <= meta_q;
    end
  end

  assign route.level = sync_q;

  // A disabled switch shows the controller an idle bus.
  always_comb begin
    if (route.ctrl.enable) begin
      rx = sync_q[route.ctrl.channel];
    end else begin
      rx = `HUB_IDLE_LEVEL;
    end
  end

endmodule

// ==== logic/activity_monitor.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module activity_monitor (
  input logic  clk,
  input logic  rst_n,
  route_if.mon route
);

  hub_pkg::chan_vec_t dominant;
  hub_pkg::chan_vec_t flags_q;

  assign dominant = route.level ^ {`HUB_NUM_CHANNELS{`HUB_IDLE_LEVEL}}; // Off idle.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= (flags_q & ~route.activity_clear) | dominant; // Set wins.
    end
  end

  assign route.activity = flags_q;

  // A flag may only drop in the cycle after software wrote a one to it.
  flag_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    ($past(flags_q) & ~flags_q & ~$past(route.activity_clear)) == '0
  ) else $error("activity_monitor: flag fell without a clear");

endmodule

// ==== logic/can_bus_switch.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module can_bus_switch (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  apb_pkg::apb_addr_t paddr,
  input  apb_pkg::apb_data_t pwdata,
  output apb_pkg::apb_data_t prdata,
  input  logic               tx,
  output logic               rx,
  output hub_pkg::chan_vec_t bus_tx,
  input  hub_pkg::chan_vec_t bus_rx
);

  route_if route ();

  switch_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .route   (route.regs)
  );

  tx_demux #(
    .idle_value (`HUB_IDLE_LEVEL)
  ) u_tx_demux (
    .tx     (tx),
    .bus_tx (bus_tx),
    .route  (route.tx)
  );

  rx_select u_rx_select (
    .clk    (clk),
    .rst_n  (rst_n),
    .bus_rx (bus_rx),
    .rx     (rx),
    .route  (route.rx)
  );

  activity_monitor u_activity (
    .clk   (clk),
    .rst_n (rst_n),
    .route (route.mon)
  );

endmodule

// ==== tb/tb_can_bus_switch.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module tb_can_bus_switch;

  logic               clk;
  logic               rst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  apb_pkg::apb_addr_t paddr;
  apb_pkg::apb_data_t pwdata;
  apb_pkg::apb_data_t prdata;
  logic               tx;
  logic               rx;
  hub_pkg::chan_vec_t bus_tx;
  hub_pkg::chan_vec_t bus_rx;
  int                 errors;
  int                 cycles;

  localparam apb_pkg::apb_data_t EN_WORD = 32'h1 << `HUB_CTRL_EN_BIT;

  can_bus_switch uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .tx      (tx),
    .rx      (rx),
    .bus_tx  (bus_tx),
    .bus_rx  (bus_rx)
  );

  always #5 clk = ~clk;

  // Guard against a hung run; the tests need only a few hundred cycles.
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 20000) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_data(input apb_pkg::apb_data_t got, input apb_pkg::apb_data_t exp,
                            input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_vec(input hub_pkg::chan_vec_t got, input hub_pkg::chan_vec_t exp,
                           input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data);
    step();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    step();
    penable = 1'b1;
    step(); // Data is captured on the edge that ends the access phase.
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data);
    step();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    step();
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    step();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // All lines recessive except the selected one, which carries the controller's bit.
  function automatic hub_pkg::chan_vec_t routed_pattern(input logic en,
                                                        input hub_pkg::channel_t ch,
                                                        input logic bit_tx);
    hub_pkg::chan_vec_t v;
    v = '1;
    if (en) v[ch] = bit_tx;
    return v;
  endfunction

  task automatic reset_state();
    apb_pkg::apb_data_t rd;
    check_vec(bus_tx, '1, "bus_tx after reset");
    check_data(apb_pkg::apb_data_t'(rx), 32'd1, "rx after reset");
    apb_read(`HUB_ADDR_CTRL, rd);
    check_data(rd, '0, "control after reset");
    apb_read(`HUB_ADDR_ACTIVITY, rd);
    check_data(rd, '0, "activity after reset");
  endtask

  task automatic tx_routing();
    hub_pkg::channel_t ch;
    for (int i = 0; i < 20; i++) begin
      ch = hub_pkg::channel_t'($urandom % `HUB_NUM_CHANNELS);
      apb_write(`HUB_ADDR_CTRL, EN_WORD | ch);
      tx = 1'b0;
      @(negedge clk);
      check_vec(bus_tx, routed_pattern(1'b1, ch, 1'b0), "bus_tx with tx low");
      step();
      tx = 1'b1;
      @(negedge clk);
      check_vec(bus_tx, routed_pattern(1'b1, ch, 1'b1), "bus_tx with tx high");
    end
  endtask

  task automatic routing_disabled();
    hub_pkg::channel_t ch;
    for (int i = 0; i < 5; i++) begin
      ch = hub_pkg::channel_t'($urandom % `HUB_NUM_CHANNELS);
      apb_write(`HUB_ADDR_CTRL, ch);
      bus_rx = '0; // Every bus dominant, yet the controller must see idle.
      tx     = 1'b0;
      @(negedge clk);
      check_vec(bus_tx, '1, "bus_tx while disabled, tx low");
      step();
      tx = 1'b1;
      repeat (2) step();
      check_vec(bus_tx, '1, "bus_tx while disabled, tx high");
      check_data(apb_pkg::apb_data_t'(rx), 32'd1, "rx while disabled");
    end
  endtask

  task automatic rx_selection();
    hub_pkg::channel_t  ch;
    hub_pkg::chan_vec_t pattern;
    apb_pkg::apb_data_t rd;
    for (int i = 0; i < 10; i++) begin
      ch = hub_pkg::channel_t'($urandom % `HUB_NUM_CHANNELS);
      apb_write(`HUB_ADDR_CTRL, EN_WORD | ch);
      pattern = $urandom;
      bus_rx  = pattern;
      repeat (2) @(posedge clk); // Two synchronizer stages.
      @(negedge clk);
      check_data(apb_pkg::apb_data_t'(rx), apb_pkg::apb_data_t'(pattern[ch]), "selected rx");
      apb_read(`HUB_ADDR_LEVEL, rd);
      check_data(rd, pattern, "level register");
    end
  endtask

  task automatic activity_flags();
    hub_pkg::chan_vec_t mask;
    hub_pkg::chan_vec_t clr;
    apb_pkg::apb_data_t rd;
    bus_rx = '1;
    repeat (3) step(); // Let the synchronizer drain before clearing.
    apb_write(`HUB_ADDR_ACTIVITY, '1);
    apb_read(`HUB_ADDR_ACTIVITY, rd);
    check_data(rd, '0, "activity after full clear");
    mask = $urandom & $urandom;
    step();
    bus_rx = ~mask;
    repeat (3) step();
    bus_rx = '1;
    apb_read(`HUB_ADDR_ACTIVITY, rd);
    check_data(rd, mask, "activity after dominant bits");
    repeat (3) step();
    apb_read(`HUB_ADDR_ACTIVITY, rd);
    check_data(rd, mask, "activity after lines returned high");
    clr = mask & $urandom;
    apb_write(`HUB_ADDR_ACTIVITY, clr);
    apb_read(`HUB_ADDR_ACTIVITY, rd);
    check_data(rd, mask & ~clr, "activity after partial clear");
  endtask

  task automatic unmapped_address();
    apb_pkg::apb_data_t rd;
    apb_write(`HUB_ADDR_CTRL, EN_WORD | 32'd7);
    bus_rx = '0; // Every bus dominant, so every flag sets.
    repeat (3) step();
    bus_rx = '1;
    apb_write(8'h0C, '1);
    apb_read(`HUB_ADDR_CTRL, rd);
    check_data(rd, EN_WORD | 32'd7, "control after unmapped write");
    apb_read(`HUB_ADDR_ACTIVITY, rd);
    check_data(rd, '1, "activity after unmapped write");
    apb_read(8'h0C, rd);
    check_data(rd, '0, "unmapped read");
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    tx      = 1'b1;
    bus_rx  = '1;
    errors  = 0;
    cycles  = 0;
    void'($urandom(1));
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state();
    tx_routing();
    routing_disabled();
    rx_selection();
    activity_flags();
    unmapped_address();
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== can_bus_switch.f ====
+incdir+logic
logic/apb_pkg.sv
logic/hub_pkg.sv
logic/route_if.sv
logic/switch_regs.sv
logic/tx_demux.sv
logic/rx_select.sv
logic/activity_monitor.sv
logic/can_bus_switch.sv
tb/tb_can_bus_switch.sv

// ==== Bender.yml ====
package:
  name: can_bus_switch

export_include_dirs:
  - logic

sources:
  - files:
      - logic/apb_pkg.sv
      - logic/hub_pkg.sv
      - logic/route_if.sv
      - logic/switch_regs.sv
      - logic/tx_demux.sv
      - logic/rx_select.sv
      - logic/activity_monitor.sv
      - logic/can_bus_switch.sv
  - target: test
    files:
      - tb/tb_can_bus_switch.sv
